// ==== src/i2c_pkg.sv ====
package i2c_pkg;

    // command opcodes as queued in the command FIFO
    typedef enum logic [1:0] {
        OP_START = 2'd0, // start, or repeated start while the bus is open
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2, // send byte, sample ack
        OP_READ  = 2'd3  // receive byte, send ack or nack
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t    op;
        logic [7:0] data; // byte to send, ignored for start/stop/read
        logic       nack; // read only, 1 makes the master nack the byte
    } cmd_t;

    // write: sent byte + sampled ack, read: received byte + ack the master sent
    typedef struct packed {
        logic [7:0] data;
        logic       ack;  // 0 = acknowledged
    } rsp_t;

    // register map
    localparam logic [1:0] CFG_DLY  = 2'd0; // phase length in mclk cycles
    localparam logic [1:0] CFG_MODE = 2'd1; // bit0 active_sda, bit1 early_release
    localparam logic [1:0] CFG_CTRL = 2'd2; // bit0 soft reset, clears itself

    localparam logic [7:0] DLY_MIN = 8'd2;  // shortest phase the engine handles

endpackage

// ==== src/i2c_cfg_regs.sv ====
`timescale 1ns/1ps

module i2c_cfg_regs #(
    parameter logic [7:0] DLY_RESET = 8'd10
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic       cfg_we,          // single cycle write strobe
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_wdata,
    output logic [7:0] i2c_dly,
    output logic       active_sda,
    output logic       early_release_0,
    output logic       i2c_rst          // one cycle pulse
);
    import i2c_pkg::*;

    always_ff @(posedge mclk) begin
        if (rst) begin
            i2c_dly         <= DLY_RESET;
            active_sda      <= 1'b0;
            early_release_0 <= 1'b0;
            i2c_rst         <= 1'b0;
        end else begin
            i2c_rst <= 1'b0; // drops again after one cycle
            if (cfg_we) begin
                case (cfg_addr)
                    // short delays get clamped, engine needs two cycles per phase
                    CFG_DLY:  i2c_dly <= (cfg_wdata < DLY_MIN) ? DLY_MIN : cfg_wdata;
                    CFG_MODE: begin
                        active_sda      <= cfg_wdata[0];
                        early_release_0 <= cfg_wdata[1];
                    end
                    CFG_CTRL: i2c_rst <= cfg_wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // covers the reset value as well as later writes
    a_dly_min: assert property (@(posedge mclk) disable iff (rst) i2c_dly >= DLY_MIN)
        else $error("i2c_dly below minimum phase length");

endmodule

// ==== src/i2c_fifo.sv ====
`timescale 1ns/1ps

module i2c_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic mclk,
    input  logic rst,
    input  logic flush,   // drops all entries
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,   // head entry, valid while !empty
    output logic full,
    output logic empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // wraps at DEPTH, so any depth works
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign rdata   = mem[rd_ptr];
    assign do_push = push && !full;  // push on full is lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge mclk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

    a_no_overflow: assert property (@(posedge mclk) disable iff (rst) push |-> !full)
        else $error("push into full FIFO dropped");

    a_no_underflow: assert property (@(posedge mclk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

// ==== src/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic       mclk,
    input  logic       rst,
    input  logic       i2c_rst,         // soft reset, same effect as rst
    input  logic [7:0] i2c_dly,         // mclk cycles per phase
    input  logic       active_sda,      // drive sda high on bits the master owns
    input  logic       early_release_0, // let go of sda right after the lsb when ack follows
    input  logic       snd_start,
    input  logic       snd_stop,
    input  logic       snd9,
    input  logic       rcv,             // qualifies snd9, slave sends the data bits
    input  logic [8:0] din,
    input  logic       sda_in,
    output logic [8:0] dout,
    output logic       dout_stb,
    output logic       scl,
    output logic       sda,
    output logic       sda_en,
    output logic       ready,
    output logic       bus_busy,
    output logic       is_open
);
    logic       rst_all;
    logic       busy;
    logic       go_start;
    logic       go_stop;
    logic       go_bit;
    logic [2:0] seq_start;  // restart enters at [2], plain start at [1]
    logic [2:0] seq_stop;
    logic [3:0] seq_bit;    // low, high, high, low
    logic [3:0] bits_left;  // 8 on the msb, 0 on the ack bit
    logic [7:0] dly_cntr;
    logic       phase_end;
    logic       last_phase;
    logic [8:0] sr;
    logic       samp;       // sda taken at the end of the high time
    logic       rcv_r;
    logic       master_bit;
    logic       early_rel;
    logic       scl_nxt;
    logic       sda_nxt;
    logic       sda_en_nxt;
    logic       sda_d;
    logic       sda_en_d;

    assign rst_all  = rst || i2c_rst;
    assign ready    = !busy;
    assign go_start = snd_start && ready;
    assign go_stop  = snd_stop && ready;
    assign go_bit   = snd9 && ready;

    assign phase_end  = busy && (dly_cntr == 8'd0);
    assign last_phase = seq_start[0] || seq_stop[0] || (seq_bit[0] && (bits_left == 4'd0));

    // data bits belong to the master on send, only the ack bit on receive
    assign master_bit = rcv_r ? (bits_left == 4'd0) : (bits_left != 4'd0);
    // hold phase of the lsb, next bit is the slave's ack
    assign early_rel  = early_release_0 && !rcv_r && (bits_left == 4'd1) && sr[7] && seq_bit[0];

    // bus levels for the current phase, idle keeps whatever is on the bus
    always_comb begin
        scl_nxt    = scl;
        sda_nxt    = sda_d;
        sda_en_nxt = sda_en_d;
        if (|seq_start) begin
            scl_nxt    = !seq_start[2];          // (0,1) (1,1) (1,0)
            sda_nxt    = !seq_start[0];
            sda_en_nxt = seq_start[0] || active_sda;
        end else if (|seq_stop) begin
            scl_nxt    = !seq_stop[2];           // (0,0) (1,0) (1,1)
            sda_nxt    = seq_stop[0];
            sda_en_nxt = !seq_stop[0] || active_sda;
        end else if (|seq_bit) begin
            scl_nxt    = seq_bit[2] || seq_bit[1];
            sda_nxt    = sr[8] || early_rel;
            sda_en_nxt = !early_rel && (!sr[8] || (active_sda && master_bit));
        end
    end

    always_ff @(posedge mclk) begin
        if (rst_all) begin
            busy      <= 1'b0;
            bus_busy  <= 1'b0;
            seq_start <= '0;
            seq_stop  <= '0;
            seq_bit   <= '0;
            bits_left <= '0;
            is_open   <= 1'b0;
            dout_stb  <= 1'b0;
            scl       <= 1'b1;
            sda_d     <= 1'b1;
            sda       <= 1'b1;
            sda_en_d  <= 1'b1;
            sda_en    <= 1'b1;
        end else begin
            bus_busy <= busy; // ready inverted, a cycle late
            dout_stb <= 1'b0;

            if (go_start || go_stop || go_bit) busy <= 1'b1;
            else if (phase_end && last_phase)  busy <= 1'b0;

            if (go_start)       seq_start <= is_open ? 3'b100 : 3'b010;
            else if (phase_end) seq_start <= seq_start >> 1;

            if (go_stop)        seq_stop <= 3'b100;
            else if (phase_end) seq_stop <= seq_stop >> 1;

            if (go_bit) begin
                seq_bit   <= 4'b1000;
                bits_left <= 4'd8;
            end else if (phase_end && seq_bit[0] && (bits_left != 4'd0)) begin
                seq_bit   <= 4'b1000; // next bit
                bits_left <= bits_left - 4'd1;
            end else if (phase_end) begin
                seq_bit <= seq_bit >> 1;
            end

            if (phase_end && seq_start[0])     is_open <= 1'b1;
            else if (phase_end && seq_stop[0]) is_open <= 1'b0;

            if (phase_end && seq_bit[0] && (bits_left == 4'd0)) dout_stb <= 1'b1;

            // sda trails scl by one cycle so both never move together
            scl      <= scl_nxt;
            sda_d    <= sda_nxt;
            sda      <= sda_d;
            sda_en_d <= sda_en_nxt;
            sda_en   <= sda_en_d;
        end
    end

    always_ff @(posedge mclk) begin
        if (go_start || go_stop || go_bit || phase_end) dly_cntr <= i2c_dly - 8'd1;
        else if (busy)                                  dly_cntr <= dly_cntr - 8'd1;

        if (go_bit) rcv_r <= rcv;

        if (phase_end && seq_bit[1]) samp <= sda_in; // end of scl high

        if (go_bit)                       sr <= din;
        else if (phase_end && seq_bit[0]) sr <= {sr[7:0], samp};

        if (phase_end && seq_bit[0] && (bits_left == 4'd0)) dout <= {sr[7:0], samp};
    end

    // strobes come from the sequencer, which must wait for ready
    a_one_strobe: assert property (@(posedge mclk) disable iff (rst_all)
        $onehot0({snd_start, snd_stop, snd9}))
        else $error("more than one engine strobe in a cycle");

    a_strobe_ready: assert property (@(posedge mclk) disable iff (rst_all)
        (snd_start || snd_stop || snd9) |-> ready)
        else $error("engine strobe while busy");

endmodule

// ==== src/i2c_cmd_seq.sv ====
`timescale 1ns/1ps

module i2c_cmd_seq (
    input  logic          mclk,
    input  logic          rst,
    input  i2c_pkg::cmd_t cmd_rdata,
    input  logic          cmd_empty,
    input  logic          rsp_full,
    input  logic          ready,
    input  logic [8:0]    dout,      // 8 data bits then ack, as seen on the bus
    output logic          cmd_pop,
    output logic          snd_start,
    output logic          snd_stop,
    output logic          snd9,
    output logic          rcv,
    output logic [8:0]    din,
    output logic          rsp_push,
    output i2c_pkg::rsp_t rsp_wdata
);
    import i2c_pkg::*;

    logic issue;      // taken this cycle, strobe and pop go out next cycle
    logic byte_op;
    logic pend;       // byte transfer in flight, owes a response
    logic ready_d;
    logic ready_rise;

    assign byte_op    = (cmd_rdata.op == OP_WRITE) || (cmd_rdata.op == OP_READ);
    assign ready_rise = ready && !ready_d;

    // cmd_pop marks the strobe cycle, ready is still high there
    // a response on its way into the FIFO also holds things back
    assign issue = ready && !cmd_empty && !rsp_full && !cmd_pop && !pend && !rsp_push;

    always_ff @(posedge mclk) begin
        if (rst) begin
            cmd_pop   <= 1'b0;
            snd_start <= 1'b0;
            snd_stop  <= 1'b0;
            snd9      <= 1'b0;
            pend      <= 1'b0;
            rsp_push  <= 1'b0;
            ready_d   <= 1'b1; // no false rise when the engine comes out of reset
        end else begin
            cmd_pop   <= issue;
            snd_start <= issue && (cmd_rdata.op == OP_START);
            snd_stop  <= issue && (cmd_rdata.op == OP_STOP);
            snd9      <= issue && byte_op;
            ready_d   <= ready;
            rsp_push  <= pend && ready_rise;

            if (issue && byte_op) pend <= 1'b1;
            else if (ready_rise)  pend <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (issue) begin
            rcv <= (cmd_rdata.op == OP_READ);
            // read: release all data bits, ack bit carries nack
            // write: byte then a released bit for the slave's ack
            if (cmd_rdata.op == OP_READ) din <= {8'hFF, cmd_rdata.nack};
            else                         din <= {cmd_rdata.data, 1'b1};
        end
        if (ready_rise) begin
            rsp_wdata.data <= dout[8:1];
            rsp_wdata.ack  <= dout[0];
        end
    end

endmodule

// ==== src/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top #(
    parameter int         FIFO_DEPTH = 4,
    parameter logic [7:0] DLY_RESET  = 8'd10
) (
    input  logic             mclk,
    input  logic             rst,
    input  logic             cfg_we,
    input  logic [1:0]       cfg_addr,
    input  logic [7:0]       cfg_wdata,
    input  logic             cmd_push,
    input  i2c_pkg::cmd_op_t cmd_op,
    input  logic [7:0]       cmd_data,
    input  logic             cmd_nack,
    input  logic             rsp_pop,
    input  logic             sda_in,
    output logic             cmd_full,
    output logic [7:0]       rsp_data,
    output logic             rsp_ack,
    output logic             rsp_empty,
    output logic             scl,
    output logic             sda,
    output logic             sda_en,
    output logic             bus_busy,
    output logic             is_open
);
    import i2c_pkg::*;

    logic [7:0] i2c_dly;
    logic       active_sda;
    logic       early_release_0;
    logic       i2c_rst;
    logic       seq_rst;
    cmd_t       cmd_wdata;
    cmd_t       cmd_rdata;
    logic       cmd_pop;
    logic       cmd_empty;
    rsp_t       rsp_wdata;
    rsp_t       rsp_rdata;
    logic       rsp_push;
    logic       rsp_full;
    logic       snd_start;
    logic       snd_stop;
    logic       snd9;
    logic       rcv;
    logic       ready;
    logic [8:0] din;
    logic [8:0] dout;

    assign cmd_wdata.op   = cmd_op;
    assign cmd_wdata.data = cmd_data;
    assign cmd_wdata.nack = cmd_nack;
    assign rsp_data       = rsp_rdata.data;
    assign rsp_ack        = rsp_rdata.ack;
    assign seq_rst        = rst || i2c_rst; // soft reset drops any pending response too

    i2c_cfg_regs #(.DLY_RESET(DLY_RESET)) u_cfg (
        .mclk(mclk), .rst(rst),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .i2c_dly(i2c_dly), .active_sda(active_sda),
        .early_release_0(early_release_0), .i2c_rst(i2c_rst)
    );

    i2c_fifo #(.T(cmd_t), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .mclk(mclk), .rst(rst), .flush(i2c_rst),
        .push(cmd_push), .wdata(cmd_wdata), .pop(cmd_pop),
        .rdata(cmd_rdata), .full(cmd_full), .empty(cmd_empty)
    );

    i2c_fifo #(.T(rsp_t), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
        .mclk(mclk), .rst(rst), .flush(i2c_rst),
        .push(rsp_push), .wdata(rsp_wdata), .pop(rsp_pop),
        .rdata(rsp_rdata), .full(rsp_full), .empty(rsp_empty)
    );

    i2c_cmd_seq u_seq (
        .mclk(mclk), .rst(seq_rst),
        .cmd_rdata(cmd_rdata), .cmd_empty(cmd_empty), .rsp_full(rsp_full),
        .ready(ready), .dout(dout),
        .cmd_pop(cmd_pop), .snd_start(snd_start), .snd_stop(snd_stop),
        .snd9(snd9), .rcv(rcv), .din(din),
        .rsp_push(rsp_push), .rsp_wdata(rsp_wdata)
    );

    // dout_stb is left open, the sequencer keys off the rise of ready
    i2c_bit_engine u_engine (
        .mclk(mclk), .rst(rst), .i2c_rst(i2c_rst),
        .i2c_dly(i2c_dly), .active_sda(active_sda), .early_release_0(early_release_0),
        .snd_start(snd_start), .snd_stop(snd_stop), .snd9(snd9), .rcv(rcv),
        .din(din), .sda_in(sda_in),
        .dout(dout), .dout_stb(),
        .scl(scl), .sda(sda), .sda_en(sda_en),
        .ready(ready), .bus_busy(bus_busy), .is_open(is_open)
    );

endmodule

// ==== dv/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic scl,
    input  logic sda_bus,    // wired-AND level seen on the bus
    output logic pull_low    // 1 pulls sda down
);
    logic       active;      // addressed since the last start
    logic       first;       // next byte is the address byte
    logic       rw;          // lsb of the address byte
    logic       reading;     // slave sends, master acks
    logic       mst_ack;
    logic [3:0] npos;        // scl rises seen in this byte
    logic [7:0] shreg;
    logic [7:0] last_wr;
    logic [7:0] tx;

    initial begin
        pull_low = 1'b0;
        active   = 1'b0;
        first    = 1'b0;
        rw       = 1'b0;
        reading  = 1'b0;
        mst_ack  = 1'b1;
        npos     = '0;
        shreg    = '0;
        last_wr  = '0;
        tx       = '0;
    end

    // start or repeated start, sda falls while scl high
    always @(negedge sda_bus) begin
        if (scl === 1'b1) begin
            active   = 1'b1;
            first    = 1'b1;
            reading  = 1'b0;
            npos     = '0;
            pull_low = 1'b0;
        end
    end

    always @(posedge sda_bus) begin
        if (scl === 1'b1) begin // stop
            active   = 1'b0;
            pull_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (npos < 4'd8 && !reading) shreg = {shreg[6:0], sda_bus};
            if (npos == 4'd8 && reading) mst_ack = sda_bus; // master ack bit
            npos = npos + 4'd1;
        end
    end

    always @(negedge scl) begin
        if (active) begin
            if (npos == 4'd8) begin
                if (!reading) begin
                    last_wr  = shreg;
                    pull_low = (shreg != 8'hFF); // ff gets a nack
                    if (first) rw = shreg[0];
                end else begin
                    pull_low = 1'b0; // master owns the ack bit
                end
            end else if (npos == 4'd9) begin
                pull_low = 1'b0;
                npos     = '0;
                if (first) begin
                    first   = 1'b0;
                    reading = rw && (last_wr != 8'hFF);
                    tx      = ~last_wr; // read data is the inverse of the last byte written
                end else if (reading && mst_ack) begin
                    reading = 1'b0; // nack ends the read
                    active  = 1'b0;
                end
                if (reading) pull_low = !tx[7];
            end else if (reading && npos >= 4'd1 && npos <= 4'd7) begin
                pull_low = !tx[4'd7 - npos];
            end
        end
    end

endmodule

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int         FIFO_DEPTH = 4;
    localparam logic [7:0] DLY_RESET  = 8'd4;
    localparam int         MAX_LINES  = 64;

    logic       mclk;
    logic       rst;
    logic       cfg_we;
    logic [1:0] cfg_addr;
    logic [7:0] cfg_wdata;
    logic       cmd_push;
    cmd_op_t    cmd_op;
    logic [7:0] cmd_data;
    logic       cmd_nack;
    logic       rsp_pop;
    logic       sda_in;
    logic       cmd_full;
    logic [7:0] rsp_data;
    logic       rsp_ack;
    logic       rsp_empty;
    logic       scl;
    logic       sda;
    logic       sda_en;
    logic       bus_busy;
    logic       is_open;
    logic       pull_low;

    logic [3:0] g_op [MAX_LINES];   // 0..3 commands, 4 delay write, 5 soft reset
    logic [7:0] g_data [MAX_LINES];
    logic       g_nack [MAX_LINES];
    logic [7:0] g_exp_data [MAX_LINES];
    logic       g_exp_ack [MAX_LINES];
    int         nlines;
    logic [8:0] exp_q [$];          // {data, ack} per byte command
    longint     limit_ns;
    logic       saw_full;
    logic       hold_rsp;           // responses stay in the FIFO while set
    int         hi_cnt;
    int         max_high;

    i2c_master_top #(.FIFO_DEPTH(FIFO_DEPTH), .DLY_RESET(DLY_RESET)) DUT (
        .mclk(mclk), .rst(rst),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cmd_push(cmd_push), .cmd_op(cmd_op), .cmd_data(cmd_data), .cmd_nack(cmd_nack),
        .rsp_pop(rsp_pop), .sda_in(sda_in),
        .cmd_full(cmd_full), .rsp_data(rsp_data), .rsp_ack(rsp_ack), .rsp_empty(rsp_empty),
        .scl(scl), .sda(sda), .sda_en(sda_en), .bus_busy(bus_busy), .is_open(is_open)
    );

    // open drain, either side can pull low
    assign sda_in = !((sda_en && !sda) || pull_low);

    i2c_slave_model u_slave (.scl(scl), .sda_bus(sda_in), .pull_low(pull_low));

    always #2 mclk = ~mclk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s (expected %0h, got %0h)",
                     $time, msg, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic push_cmd(input logic [1:0] op, input logic [7:0] data, input logic nack);
        repeat ($urandom % 3) @(negedge mclk); // random gap
        while (cmd_full) @(negedge mclk);
        cmd_op   = cmd_op_t'(op);
        cmd_data = data;
        cmd_nack = nack;
        cmd_push = 1'b1;
        @(negedge mclk);
        cmd_push = 1'b0;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge mclk);
        cfg_we    = 1'b0;
    endtask

    task automatic wait_open(input logic level);
        while (is_open !== level) @(negedge mclk);
    endtask

    // response checker, pops every entry in order
    always @(negedge mclk) begin
        logic [8:0] exp;
        rsp_pop = 1'b0;
        if (!rst && !hold_rsp && rsp_empty === 1'b0) begin
            if (exp_q.size() == 0) begin
                fail_with("response arrived with no byte command pending");
            end else begin
                exp = exp_q.pop_front();
                check_value(rsp_data, exp[8:1], "response data");
                check_value(rsp_ack, exp[0], "response ack");
                check_value(is_open, 1'b1, "bus open during byte transfer");
                rsp_pop = 1'b1;
            end
        end
    end

    // cmd_full seen, longest scl high pulse inside an open transaction
    always @(negedge mclk) begin
        if (cmd_full === 1'b1) saw_full = 1'b1;
        if (is_open !== 1'b1) begin
            hi_cnt = 0;
        end else if (scl === 1'b1) begin
            hi_cnt = hi_cnt + 1;
        end else begin
            if (hi_cnt > max_high) max_high = hi_cnt;
            hi_cnt = 0;
        end
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: the test did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          fd;
        string       line;
        int          n;
        logic [31:0] f0, f1, f2, f3, f4;
        logic [7:0]  max_dly;
        logic [7:0]  cur_dly;
        int          hi_before;
        logic        dly_raised;

        mclk       = 1'b0;
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        cmd_push   = 1'b0;
        cmd_op     = OP_START;
        cmd_data   = '0;
        cmd_nack   = 1'b0;
        rsp_pop    = 1'b0;
        nlines     = 0;
        limit_ns   = 0;
        saw_full   = 1'b0;
        hold_rsp   = 1'b0;
        hi_cnt     = 0;
        max_high   = 0;
        hi_before  = 0;
        dly_raised = 1'b0;
        void'($urandom(73));
        max_dly    = DLY_RESET;
        cur_dly    = DLY_RESET;

        fd = $fopen("dv/i2c_golden.txt", "r");
        if (fd == 0) fail_with("cannot open dv/i2c_golden.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4) != 5) continue;
            g_op[nlines]       = f0[3:0];
            g_data[nlines]     = f1[7:0];
            g_nack[nlines]     = f2[0];
            g_exp_data[nlines] = f3[7:0];
            g_exp_ack[nlines]  = f4[0];
            if (f0 == 4 && f1[7:0] > max_dly) max_dly = f1[7:0];
            nlines++;
        end
        $fclose(fd);

        // a byte is 36 phases, the rest is slack for queueing
        limit_ns = longint'(nlines) * (40 * max_dly + 40) * 4 + 1000;

        repeat (2) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;

        for (int i = 0; i < nlines; i++) begin
            case (g_op[i])
                4'd0, 4'd1: begin // start/stop, exp ack column is the is_open level after
                    push_cmd(g_op[i][1:0], 8'h00, 1'b0);
                    wait_open(g_exp_ack[i]);
                end
                4'd2, 4'd3: begin
                    exp_q.push_back({g_exp_data[i], g_exp_ack[i]});
                    push_cmd(g_op[i][1:0], g_data[i], g_nack[i]);
                end
                4'd4: begin
                    hi_before  = max_high;
                    max_high   = 0;
                    dly_raised = (g_data[i] > cur_dly);
                    cur_dly    = g_data[i];
                    cfg_write(CFG_DLY, g_data[i]);
                end
                4'd5: begin
                    hold_rsp = 1'b1; // keep the next response in the FIFO
                    while (rsp_empty !== 1'b0) @(negedge mclk);
                    // one write goes to the engine, the rest fill the command FIFO
                    repeat (FIFO_DEPTH + 1) push_cmd(OP_WRITE, 8'h77, 1'b0);
                    check_value(cmd_full, 1'b1, "cmd_full before soft reset");
                    check_value(rsp_empty, 1'b0, "rsp_empty before soft reset");
                    check_value(bus_busy, 1'b1, "bus_busy during transfer");
                    cfg_write(CFG_CTRL, g_data[i]);
                    exp_q.delete(); // held response and queued writes are flushed
                    repeat (4) @(negedge mclk);
                    check_value(rsp_empty, 1'b1, "rsp_empty after soft reset");
                    check_value(cmd_full, 1'b0, "cmd_full after soft reset");
                    check_value(is_open, 1'b0, "is_open after soft reset");
                    check_value(bus_busy, 1'b0, "bus_busy after soft reset");
                    check_value({scl, sda, sda_en}, 3'b111, "bus lines after soft reset");
                    hold_rsp = 1'b0;
                end
                default: fail_with("unknown operation in golden file");
            endcase
        end

        repeat (8) @(negedge mclk);
        check_value(saw_full, 1'b1, "cmd_full during back to back pushes");
        if (dly_raised) check_value(max_high > hi_before, 1'b1, "scl high longer after delay");

        if (exp_q.size() != 0) begin
            $display("responses still missing at the end of the test");
            $display("Result: FAILED");
            $fatal(1, "missing responses");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== dv/i2c_golden.txt ====
# columns (hex): op data nack exp_data exp_ack
# op 0 start 1 stop 2 write 3 read 4 delay write 5 soft reset, start/stop exp_ack is is_open
0 00 0 00 1
2 A0 0 A0 0
2 5A 0 5A 0
2 FF 0 FF 1
2 C3 0 C3 0
0 00 0 00 1
2 A1 0 A1 0
3 00 0 5E 0
3 00 1 5E 1
1 00 0 00 0
0 00 0 00 1
2 A0 0 A0 0
2 11 0 11 0
2 22 0 22 0
2 33 0 33 0
2 44 0 44 0
2 55 0 55 0
1 00 0 00 0
4 0C 0 00 0
0 00 0 00 1
2 A0 0 A0 0
2 96 0 96 0
0 00 0 00 1
2 A1 0 A1 0
3 00 1 5E 1
1 00 0 00 0
0 00 0 00 1
2 A0 0 A0 0
5 01 0 00 0
0 00 0 00 1
2 3C 0 3C 0
1 00 0 00 0

// ==== flist.f ====
src/i2c_pkg.sv
src/i2c_cfg_regs.sv
src/i2c_fifo.sv
src/i2c_bit_engine.sv
src/i2c_cmd_seq.sv
src/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_i2c_master -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
